/* hw/issue_settings.svh */
/* Sizing macros for the issue stage, shared by the package and every RTL module.
   Include this header wherever a warp count, buffer depth or data width is needed */

`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Number of warps; each warp is a single lane
`define ISSUE_NUM_WARPS 4

// Entries in each per-warp instruction buffer
`define ISSUE_IBUF_DEPTH 2

// Register and datapath width
`define ISSUE_XLEN 32

// Architectural registers per warp, register 0 is hardwired to zero
`define ISSUE_NUM_REGS 32

`endif

/* hw/issue_pkg.sv */
/* Types shared across the issue stage: the decoded instruction, the src2 operand word,
   the writeback strobe payload and the dispatch payload */

`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    typedef logic [$clog2(`ISSUE_NUM_WARPS)-1:0] wid_t;

    typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0] reg_t;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_t;

    // Register view of the src2 field, upper bits carry nothing
    typedef struct packed {
        logic [6:0] pad;
        reg_t       rs2;
    } src2_reg_t;

    // use_imm selects which view of this word is meaningful
    typedef union packed {
        src2_reg_t          rf;
        logic signed [11:0] imm;
    } src2_u;

    typedef struct packed {
        wid_t        wid;
        logic [31:0] pc;
        ex_type_t    ex_type;
        logic [3:0]  op;
        logic        wb;
        reg_t        rd;
        reg_t        rs1;
        logic        use_imm;
        src2_u       src2;
    } instr_t;

    typedef struct packed {
        wid_t                   wid;
        reg_t                   rd;
        logic [`ISSUE_XLEN-1:0] data;
    } writeback_t;

    typedef struct packed {
        wid_t                   wid;
        logic [31:0]            pc;
        logic [3:0]             op;
        logic                   wb;
        reg_t                   rd;
        logic [`ISSUE_XLEN-1:0] rs1_data;
        logic [`ISSUE_XLEN-1:0] src2_data;
    } dispatch_t;

endpackage

`default_nettype wire

/* hw/issue_ibuffer.sv */
/* Per-warp instruction FIFOs. The decode port pushes into the FIFO named by the
   instruction's warp id and the scoreboard pops heads with a one-hot vector */

`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module issue_ibuffer (
    input  wire logic                                         clk,
    input  wire logic                                         reset,

    input  wire logic                                         decode_valid,
    input  wire issue_pkg::instr_t                            decode_data,
    output logic                                              decode_ready,

    input  wire logic [`ISSUE_NUM_WARPS-1:0]                  pop,
    output logic [`ISSUE_NUM_WARPS-1:0]                       head_valid,
    output issue_pkg::instr_t [`ISSUE_NUM_WARPS-1:0]          head_data
);
    import issue_pkg::*;

    localparam int DEPTH    = `ISSUE_IBUF_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [`ISSUE_NUM_WARPS-1:0] full;
    logic                        push;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Space is judged only by the addressed warp, other warps never stall this one
    assign decode_ready = ~full[decode_data.wid];
    assign push         = decode_valid && decode_ready;

    for (genvar w = 0; w < `ISSUE_NUM_WARPS; w++) begin : g_warp
        instr_t              mem [DEPTH];
        logic [PTR_BITS-1:0] rd_ptr;
        logic [PTR_BITS-1:0] wr_ptr;
        logic [CNT_BITS-1:0] count;
        logic                push_w;

        assign push_w = push && (decode_data.wid == wid_t'(w));

        always_ff @(posedge clk) begin
            if (push_w) begin
                mem[wr_ptr] <= decode_data;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push_w) begin
                    wr_ptr <= next_ptr(wr_ptr);
                end
                if (pop[w]) begin
                    rd_ptr <= next_ptr(rd_ptr);
                end
                // A simultaneous push and pop leaves the count unchanged
                case ({push_w, pop[w]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        assign full[w]       = (count == CNT_BITS'(DEPTH));
        assign head_valid[w] = (count != '0);
        assign head_data[w]  = mem[rd_ptr];
    end

endmodule

`default_nettype wire

/* hw/issue_scoreboard.sv */
/* Scoreboard with per-warp pending-register bits. Picks a hazard-free warp head in
   round-robin order and holds it in a one-deep valid/ready output register */

`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module issue_scoreboard (
    input  wire logic                                         clk,
    input  wire logic                                         reset,

    input  wire logic [`ISSUE_NUM_WARPS-1:0]                  head_valid,
    input  wire issue_pkg::instr_t [`ISSUE_NUM_WARPS-1:0]     head_data,
    output logic [`ISSUE_NUM_WARPS-1:0]                       pop,

    input  wire logic                                         writeback_valid,
    input  wire issue_pkg::writeback_t                        writeback_data,

    output logic                                              sched_valid,
    output issue_pkg::instr_t                                 sched_data,
    input  wire logic                                         sched_ready
);
    import issue_pkg::*;

    logic [`ISSUE_NUM_WARPS-1:0][`ISSUE_NUM_REGS-1:0] pending;
    logic [`ISSUE_NUM_WARPS-1:0]                      warp_ready;

    wid_t   last_wid;
    wid_t   pick_wid;
    logic   pick_valid;
    instr_t pick_instr;
    logic   take;
    logic   issue;

    // A head may go when none of the registers it touches has a write in flight
    always_comb begin
        for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
            warp_ready[w] = head_valid[w]
                && !pending[w][head_data[w].rs1]
                && (head_data[w].use_imm || !pending[w][head_data[w].src2.rf.rs2])
                && (!head_data[w].wb || !pending[w][head_data[w].rd]);
        end
    end

    // Search starts one past the last granted warp
    always_comb begin
        pick_valid = 1'b0;
        pick_wid   = last_wid;
        for (int i = 1; i <= `ISSUE_NUM_WARPS; i++) begin
            if (!pick_valid && warp_ready[(int'(last_wid) + i) % `ISSUE_NUM_WARPS]) begin
                pick_valid = 1'b1;
                pick_wid   = wid_t'((int'(last_wid) + i) % `ISSUE_NUM_WARPS);
            end
        end
    end

    assign pick_instr = head_data[pick_wid];
    assign take       = !sched_valid || sched_ready;
    assign issue      = take && pick_valid;

    always_comb begin
        pop = '0;
        if (issue) begin
            pop[pick_wid] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sched_valid <= 1'b0;
            last_wid    <= wid_t'(`ISSUE_NUM_WARPS - 1);
        end else if (take) begin
            sched_valid <= pick_valid;
            if (pick_valid) begin
                last_wid <= pick_wid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            sched_data <= pick_instr;
        end
    end

    // Set and clear never target the same bit in one edge, a pending rd blocks issue
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (writeback_valid) begin
                pending[writeback_data.wid][writeback_data.rd] <= 1'b0;
            end
            if (issue && pick_instr.wb && (pick_instr.rd != '0)) begin
                pending[pick_wid][pick_instr.rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/issue_operands.sv */
/* Per-warp register file with its writeback port, and the operand-read stage that
   fills in rs1 and src2 values before dispatch */

`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module issue_operands (
    input  wire logic                    clk,
    input  wire logic                    reset,

    input  wire logic                    sched_valid,
    input  wire issue_pkg::instr_t       sched_data,
    output logic                         sched_ready,

    input  wire logic                    writeback_valid,
    input  wire issue_pkg::writeback_t   writeback_data,

    output logic                         opnd_valid,
    output issue_pkg::dispatch_t         opnd_data,
    output issue_pkg::ex_type_t          opnd_ex_type,
    input  wire logic                    opnd_ready
);
    import issue_pkg::*;

    logic [`ISSUE_XLEN-1:0] rf [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS];

    logic [`ISSUE_XLEN-1:0] rs1_val;
    logic [`ISSUE_XLEN-1:0] rs2_val;
    logic [`ISSUE_XLEN-1:0] imm_val;
    dispatch_t              next_data;
    reg_t                   rs2;

    // Writes to register 0 are dropped; its reads are forced to zero below
    always_ff @(posedge clk) begin
        if (writeback_valid && (writeback_data.rd != '0)) begin
            rf[writeback_data.wid][writeback_data.rd] <= writeback_data.data;
        end
    end

    assign rs2 = sched_data.src2.rf.rs2;

    assign rs1_val = (sched_data.rs1 == '0) ? '0 : rf[sched_data.wid][sched_data.rs1];
    assign rs2_val = (rs2 == '0) ? '0 : rf[sched_data.wid][rs2];

    // Immediate view of the same src2 word, sign-extended to the datapath width
    assign imm_val = {{(`ISSUE_XLEN - 12){sched_data.src2.imm[11]}}, sched_data.src2.imm};

    always_comb begin
        next_data.wid       = sched_data.wid;
        next_data.pc        = sched_data.pc;
        next_data.op        = sched_data.op;
        next_data.wb        = sched_data.wb;
        next_data.rd        = sched_data.rd;
        next_data.rs1_data  = rs1_val;
        next_data.src2_data = sched_data.use_imm ? imm_val : rs2_val;
    end

    assign sched_ready = !opnd_valid || opnd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            opnd_valid <= 1'b0;
        end else if (sched_ready) begin
            opnd_valid <= sched_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sched_ready && sched_valid) begin
            opnd_data    <= next_data;
            opnd_ex_type <= sched_data.ex_type;
        end
    end

endmodule

`default_nettype wire

/* hw/issue_dispatch.sv */
/* Combinational router from the operand stage to the ALU, LSU and SFU ports.
   Payload fans out to all ports and only the selected unit sees valid */

`timescale 1ns/10ps
`default_nettype none

module issue_dispatch (
    input  wire logic                    opnd_valid,
    input  wire issue_pkg::dispatch_t    opnd_data,
    input  wire issue_pkg::ex_type_t     opnd_ex_type,
    output logic                         opnd_ready,

    output logic                         alu_valid,
    output issue_pkg::dispatch_t         alu_data,
    input  wire logic                    alu_ready,

    output logic                         lsu_valid,
    output issue_pkg::dispatch_t         lsu_data,
    input  wire logic                    lsu_ready,

    output logic                         sfu_valid,
    output issue_pkg::dispatch_t         sfu_data,
    input  wire logic                    sfu_ready
);
    import issue_pkg::*;

    assign alu_data = opnd_data;
    assign lsu_data = opnd_data;
    assign sfu_data = opnd_data;

    // One decode drives both the port valid and the returned ready
    always_comb begin
        alu_valid  = 1'b0;
        lsu_valid  = 1'b0;
        sfu_valid  = 1'b0;
        opnd_ready = 1'b0;
        case (opnd_ex_type)
            EX_ALU: begin
                alu_valid  = opnd_valid;
                opnd_ready = alu_ready;
            end
            EX_LSU: begin
                lsu_valid  = opnd_valid;
                opnd_ready = lsu_ready;
            end
            EX_SFU: begin
                sfu_valid  = opnd_valid;
                opnd_ready = sfu_ready;
            end
            // An unknown unit type has no port; it is consumed so the pipe keeps moving
            default: opnd_ready = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* hw/issue_stage.sv */
/* Top of the issue stage: instruction buffers, scoreboard, operand read and dispatch.
   Decode feeds in, writeback strobes come back, three execution ports go out */

`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module issue_stage (
    input  wire logic                    clk,
    input  wire logic                    reset,

    input  wire logic                    decode_valid,
    input  wire issue_pkg::instr_t       decode_data,
    output logic                         decode_ready,

    input  wire logic                    writeback_valid,
    input  wire issue_pkg::writeback_t   writeback_data,

    output logic                         alu_valid,
    output issue_pkg::dispatch_t         alu_data,
    input  wire logic                    alu_ready,

    output logic                         lsu_valid,
    output issue_pkg::dispatch_t         lsu_data,
    input  wire logic                    lsu_ready,

    output logic                         sfu_valid,
    output issue_pkg::dispatch_t         sfu_data,
    input  wire logic                    sfu_ready
);
    import issue_pkg::*;

    logic [`ISSUE_NUM_WARPS-1:0]   head_valid;
    instr_t [`ISSUE_NUM_WARPS-1:0] head_data;
    logic [`ISSUE_NUM_WARPS-1:0]   pop;

    logic      sched_valid;
    instr_t    sched_data;
    logic      sched_ready;

    logic      opnd_valid;
    dispatch_t opnd_data;
    ex_type_t  opnd_ex_type;
    logic      opnd_ready;

    issue_ibuffer i_issue_ibuffer (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode_data  (decode_data),
        .decode_ready (decode_ready),
        .pop          (pop),
        .head_valid   (head_valid),
        .head_data    (head_data)
    );

    issue_scoreboard i_issue_scoreboard (
        .clk             (clk),
        .reset           (reset),
        .head_valid      (head_valid),
        .head_data       (head_data),
        .pop             (pop),
        .writeback_valid (writeback_valid),
        .writeback_data  (writeback_data),
        .sched_valid     (sched_valid),
        .sched_data      (sched_data),
        .sched_ready     (sched_ready)
    );

    // The writeback strobe reaches both the register file and the pending bits
    issue_operands i_issue_operands (
        .clk             (clk),
        .reset           (reset),
        .sched_valid     (sched_valid),
        .sched_data      (sched_data),
        .sched_ready     (sched_ready),
        .writeback_valid (writeback_valid),
        .writeback_data  (writeback_data),
        .opnd_valid      (opnd_valid),
        .opnd_data       (opnd_data),
        .opnd_ex_type    (opnd_ex_type),
        .opnd_ready      (opnd_ready)
    );

    issue_dispatch i_issue_dispatch (
        .opnd_valid   (opnd_valid),
        .opnd_data    (opnd_data),
        .opnd_ex_type (opnd_ex_type),
        .opnd_ready   (opnd_ready),
        .alu_valid    (alu_valid),
        .alu_data     (alu_data),
        .alu_ready    (alu_ready),
        .lsu_valid    (lsu_valid),
        .lsu_data     (lsu_data),
        .lsu_ready    (lsu_ready),
        .sfu_valid    (sfu_valid),
        .sfu_data     (sfu_data),
        .sfu_ready    (sfu_ready)
    );

endmodule

`default_nettype wire

/* test/issue_stage_assertions.sv */
/* Protocol checks bound into the issue stage: one dispatch port at a time,
   stalled ports hold steady, and decode is ready as soon as reset ends */

`timescale 1ns/10ps
`default_nettype none

module issue_stage_assertions (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 decode_ready,
    input wire logic                 alu_valid,
    input wire issue_pkg::dispatch_t alu_data,
    input wire logic                 alu_ready,
    input wire logic                 lsu_valid,
    input wire issue_pkg::dispatch_t lsu_data,
    input wire logic                 lsu_ready,
    input wire logic                 sfu_valid,
    input wire issue_pkg::dispatch_t sfu_data,
    input wire logic                 sfu_ready
);

    int failures = 0;

    single_port: assert property (@(posedge clk) disable iff (reset)
        $onehot0({alu_valid, lsu_valid, sfu_valid}))
        else begin
            failures++;
            $error("More than one dispatch port is valid");
        end

    // A refused transfer must be offered again unchanged
    alu_hold: assert property (@(posedge clk) disable iff (reset)
        alu_valid && !alu_ready |=> alu_valid && $stable(alu_data))
        else begin
            failures++;
            $error("ALU port dropped or changed a stalled dispatch");
        end

    lsu_hold: assert property (@(posedge clk) disable iff (reset)
        lsu_valid && !lsu_ready |=> lsu_valid && $stable(lsu_data))
        else begin
            failures++;
            $error("LSU port dropped or changed a stalled dispatch");
        end

    sfu_hold: assert property (@(posedge clk) disable iff (reset)
        sfu_valid && !sfu_ready |=> sfu_valid && $stable(sfu_data))
        else begin
            failures++;
            $error("SFU port dropped or changed a stalled dispatch");
        end

    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> decode_ready)
        else begin
            failures++;
            $error("decode_ready is low in the first cycle after reset");
        end

endmodule

bind issue_stage issue_stage_assertions i_issue_stage_assertions (
    .clk          (clk),
    .reset        (reset),
    .decode_ready (decode_ready),
    .alu_valid    (alu_valid),
    .alu_data     (alu_data),
    .alu_ready    (alu_ready),
    .lsu_valid    (lsu_valid),
    .lsu_data     (lsu_data),
    .lsu_ready    (lsu_ready),
    .sfu_valid    (sfu_valid),
    .sfu_data     (sfu_data),
    .sfu_ready    (sfu_ready)
);

`default_nettype wire

/* test/issue_stage_tb.sv */
/* Directed testbench for the issue stage. It plays the decoder, the writeback source and
   the three execution units, and checks every dispatch against a reference model */

`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module issue_stage_tb;
    import issue_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_TESTS   = 6;
    localparam int DRAIN_LIMIT = 100;

    logic       clk;
    logic       reset;
    logic       decode_valid;
    instr_t     decode_data;
    logic       decode_ready;
    logic       writeback_valid;
    writeback_t writeback_data;
    logic       alu_valid;
    dispatch_t  alu_data;
    logic       alu_ready;
    logic       lsu_valid;
    dispatch_t  lsu_data;
    logic       lsu_ready;
    logic       sfu_valid;
    dispatch_t  sfu_data;
    logic       sfu_ready;

    // Reference register file and the dispatches each port still owes
    logic [`ISSUE_XLEN-1:0] ref_rf [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS];
    dispatch_t              alu_q[$];
    dispatch_t              lsu_q[$];
    dispatch_t              sfu_q[$];

    integer      seed;
    logic [31:0] next_pc;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          assert_failures;

    issue_stage i_issue_stage (
        .clk             (clk),
        .reset           (reset),
        .decode_valid    (decode_valid),
        .decode_data     (decode_data),
        .decode_ready    (decode_ready),
        .writeback_valid (writeback_valid),
        .writeback_data  (writeback_data),
        .alu_valid       (alu_valid),
        .alu_data        (alu_data),
        .alu_ready       (alu_ready),
        .lsu_valid       (lsu_valid),
        .lsu_data        (lsu_data),
        .lsu_ready       (lsu_ready),
        .sfu_valid       (sfu_valid),
        .sfu_data        (sfu_data),
        .sfu_ready       (sfu_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Budget of 400 cycles per test
    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("Watchdog expired at %0t before all tests completed", $time);
        $display("Finished with errors");
        $finish;
    end

    function automatic instr_t make_instr(input wid_t wid, input ex_type_t ex, input logic wb,
                                          input reg_t rd, input reg_t rs1, input logic use_imm,
                                          input logic [11:0] src2);
        instr_t ins;
        ins         = '0;
        ins.wid     = wid;
        ins.pc      = next_pc;
        ins.ex_type = ex;
        ins.op      = next_pc[5:2];
        ins.wb      = wb;
        ins.rd      = rd;
        ins.rs1     = rs1;
        ins.use_imm = use_imm;
        ins.src2    = src2;
        next_pc     = next_pc + 32'd4;
        return ins;
    endfunction

    // Register 0 reads zero; the immediate is sign-extended from bit 11
    task automatic expect_dispatch(input instr_t ins);
        dispatch_t d;
        d.wid      = ins.wid;
        d.pc       = ins.pc;
        d.op       = ins.op;
        d.wb       = ins.wb;
        d.rd       = ins.rd;
        d.rs1_data = ref_rf[ins.wid][ins.rs1];
        if (ins.use_imm) begin
            d.src2_data = ins.src2.imm[11] ? {20'hfffff, ins.src2.imm} : {20'h00000, ins.src2.imm};
        end else begin
            d.src2_data = ref_rf[ins.wid][ins.src2.rf.rs2];
        end
        case (ins.ex_type)
            EX_LSU:  lsu_q.push_back(d);
            EX_SFU:  sfu_q.push_back(d);
            default: alu_q.push_back(d);
        endcase
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_port(input int port, input string name, input dispatch_t got);
        dispatch_t exp;
        logic      have;
        have = 1'b0;
        if (port == 0 && alu_q.size() > 0) begin
            exp  = alu_q.pop_front();
            have = 1'b1;
        end else if (port == 1 && lsu_q.size() > 0) begin
            exp  = lsu_q.pop_front();
            have = 1'b1;
        end else if (port == 2 && sfu_q.size() > 0) begin
            exp  = sfu_q.pop_front();
            have = 1'b1;
        end
        assert (have) else begin
            $display("%0t: %s carried an instruction that no test expected there", $time, name);
            error_count++;
        end
        if (have) begin
            assert (got == exp) else begin
                $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
                error_count++;
            end
        end
    endtask

    // Every accepted dispatch is compared with the head of its port's queue
    always @(posedge clk) begin
        if (!reset) begin
            if (alu_valid && alu_ready) begin
                check_port(0, "alu_data", alu_data);
            end
            if (lsu_valid && lsu_ready) begin
                check_port(1, "lsu_data", lsu_data);
            end
            if (sfu_valid && sfu_ready) begin
                check_port(2, "sfu_data", sfu_data);
            end
        end
    end

    task automatic write_reg(input wid_t wid, input reg_t rd, input logic [31:0] data);
        if (rd != '0) begin
            ref_rf[wid][rd] = data;
        end
        writeback_valid     = 1'b1;
        writeback_data.wid  = wid;
        writeback_data.rd   = rd;
        writeback_data.data = data;
        @(posedge clk);
        #1;
        writeback_valid = 1'b0;
    endtask

    task automatic preload_reg(input wid_t wid, input reg_t rd);
        write_reg(wid, rd, $random(seed));
    endtask

    task automatic send_instr(input instr_t ins);
        decode_valid = 1'b1;
        decode_data  = ins;
        @(posedge clk);
        while (!decode_ready) begin
            @(posedge clk);
        end
        #1;
        decode_valid = 1'b0;
    endtask

    task automatic wait_drain(input string name);
        int cycles;
        cycles = 0;
        while ((alu_q.size() + lsu_q.size() + sfu_q.size()) != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert ((alu_q.size() + lsu_q.size() + sfu_q.size()) == 0) else begin
            $display("%0t: %s left %0d expected dispatches that never arrived", $time, name,
                     alu_q.size() + lsu_q.size() + sfu_q.size());
            error_count++;
            alu_q.delete();
            lsu_q.delete();
            sfu_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, error_count - errors_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic reset_state;
        int errors_before;
        errors_before = error_count;
        repeat (3) begin
            @(posedge clk);
            check_level("alu_valid", alu_valid, 1'b0);
            check_level("lsu_valid", lsu_valid, 1'b0);
            check_level("sfu_valid", sfu_valid, 1'b0);
            check_level("decode_ready", decode_ready, 1'b1);
        end
        #1;
        report_test("reset state", errors_before);
    endtask

    task automatic immediate_operand;
        int     errors_before;
        int     edges;
        instr_t ins;
        errors_before = error_count;
        preload_reg(2'd0, 5'd3);
        preload_reg(2'd0, 5'd4);
        preload_reg(2'd0, 5'd0);
        // Immediate of -100
        ins = make_instr(2'd0, EX_ALU, 1'b0, 5'd9, 5'd3, 1'b1, 12'hf9c);
        expect_dispatch(ins);
        send_instr(ins);
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (!alu_valid && edges < 10);
        #1;
        assert (edges == 3) else begin
            $display("%0t: ALU dispatch arrived %0d edges after acceptance, not 3", $time, edges);
            error_count++;
        end
        wait_drain("immediate operand");
        ins = make_instr(2'd0, EX_ALU, 1'b0, 5'd9, 5'd0, 1'b0, 12'd4);
        expect_dispatch(ins);
        send_instr(ins);
        wait_drain("register zero read");
        report_test("immediate operand", errors_before);
    endtask

    task automatic unit_routing;
        int     errors_before;
        instr_t ins;
        errors_before = error_count;
        for (int r = 1; r <= 4; r++) begin
            preload_reg(2'd3, reg_t'(r));
        end
        lsu_ready = 1'b0;
        sfu_ready = 1'b0;
        ins = make_instr(2'd3, EX_ALU, 1'b0, 5'd10, 5'd1, 1'b0, 12'd2);
        expect_dispatch(ins);
        send_instr(ins);
        ins = make_instr(2'd3, EX_LSU, 1'b0, 5'd11, 5'd3, 1'b0, 12'd4);
        expect_dispatch(ins);
        send_instr(ins);
        ins = make_instr(2'd3, EX_SFU, 1'b0, 5'd12, 5'd2, 1'b0, 12'd3);
        expect_dispatch(ins);
        send_instr(ins);
        // The LSU and SFU instructions each wait on their own unit's ready
        repeat (6) @(posedge clk);
        #1;
        lsu_ready = 1'b1;
        repeat (6) @(posedge clk);
        #1;
        sfu_ready = 1'b1;
        wait_drain("unit routing");
        report_test("unit routing", errors_before);
    endtask

    task automatic raw_hazard;
        int     errors_before;
        instr_t producer;
        instr_t consumer;
        errors_before = error_count;
        preload_reg(2'd0, 5'd1);
        preload_reg(2'd0, 5'd2);
        producer = make_instr(2'd0, EX_ALU, 1'b1, 5'd5, 5'd1, 1'b1, 12'h010);
        expect_dispatch(producer);
        send_instr(producer);
        wait_drain("hazard producer");
        consumer = make_instr(2'd0, EX_ALU, 1'b0, 5'd6, 5'd5, 1'b0, 12'd2);
        send_instr(consumer);
        // r5 stays pending until the writeback below
        repeat (20) begin
            @(posedge clk);
            check_level("alu_valid", alu_valid, 1'b0);
        end
        #1;
        preload_reg(2'd0, 5'd5);
        expect_dispatch(consumer);
        wait_drain("hazard consumer");
        report_test("read-after-write hazard", errors_before);
    endtask

    task automatic warp_independence;
        int     errors_before;
        instr_t ins;
        instr_t blocked;
        errors_before = error_count;
        preload_reg(2'd1, 5'd2);
        preload_reg(2'd2, 5'd1);
        preload_reg(2'd2, 5'd2);
        ins = make_instr(2'd1, EX_LSU, 1'b1, 5'd7, 5'd2, 1'b1, 12'h7ff);
        expect_dispatch(ins);
        send_instr(ins);
        wait_drain("warp 1 producer");
        blocked = make_instr(2'd1, EX_LSU, 1'b0, 5'd8, 5'd7, 1'b1, 12'd5);
        send_instr(blocked);
        // Warp 2 must flow past the stalled warp 1 head
        for (int k = 0; k < 3; k++) begin
            ins = make_instr(2'd2, EX_ALU, 1'b0, 5'd3, 5'd1, 1'b0, 12'd2);
            expect_dispatch(ins);
            send_instr(ins);
        end
        wait_drain("warp 2 traffic");
        check_level("lsu_valid", lsu_valid, 1'b0);
        preload_reg(2'd1, 5'd7);
        expect_dispatch(blocked);
        wait_drain("warp 1 release");
        report_test("warp independence", errors_before);
    endtask

    task automatic back_pressure;
        int     errors_before;
        instr_t burst [10];
        errors_before = error_count;
        preload_reg(2'd2, 5'd1);
        alu_ready = 1'b0;
        for (int k = 0; k < 10; k++) begin
            burst[k] = make_instr(2'd2, EX_ALU, 1'b0, 5'd4, 5'd1, 1'b1, 12'(k * 3));
            expect_dispatch(burst[k]);
        end
        // Two buffer entries plus the scoreboard and operand registers
        for (int k = 0; k < 4; k++) begin
            send_instr(burst[k]);
        end
        decode_valid = 1'b1;
        decode_data  = burst[4];
        repeat (8) begin
            @(posedge clk);
            check_level("decode_ready", decode_ready, 1'b0);
        end
        #1;
        alu_ready = 1'b1;
        for (int k = 4; k < 10; k++) begin
            send_instr(burst[k]);
        end
        wait_drain("back-pressure burst");
        report_test("back-pressure", errors_before);
    endtask

    initial begin
        seed            = 78089;
        next_pc         = 32'h0000_1000;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        assert_failures = 0;
        reset           = 1'b1;
        decode_valid    = 1'b0;
        decode_data     = '0;
        writeback_valid = 1'b0;
        writeback_data  = '0;
        alu_ready       = 1'b1;
        lsu_ready       = 1'b1;
        sfu_ready       = 1'b1;
        for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
            ref_rf[w][0] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_state();
        immediate_operand();
        unit_routing();
        raw_hazard();
        warp_independence();
        back_pressure();

        assert_failures = i_issue_stage.i_issue_stage_assertions.failures;
        $display("Tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/issue_pkg.sv
hw/issue_ibuffer.sv
hw/issue_scoreboard.sv
hw/issue_operands.sv
hw/issue_dispatch.sv
hw/issue_stage.sv
test/issue_stage_assertions.sv
test/issue_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= issue_stage_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
